// ==== all.f ====
+incdir+dv
design/link_pkg.sv
design/fifo_fwft.sv
design/delay_lane.sv
design/interconnect_model.sv
dv/tb_interconnect.sv

// ==== Makefile ====
TOP := tb_interconnect
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f design/*.sv dv/*.sv dv/*.svh
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps \
		-f all.f --top-module interconnect_model

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// inputs change 1 ns after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
        errors++;
        $display("error: %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    end
endtask

task automatic check_true(logic cond, string what);
    checks++;
    assert (cond) else begin
        errors++;
        $display("error: %s: %s", test_name, what);
    end
endtask

// lane number in the top nibble exposes cross-channel mixing
function automatic link_pkg::word_t tag_word(int l, int seq);
    return link_pkg::word_t'((l << 12) | (seq & 'hfff));
endfunction

task automatic drive_word(int l, link_pkg::word_t data, logic valid);
    if (l < CH) begin
        upstream_in_data[l*W +: W] = data;
        upstream_in_valid[l]       = valid;
    end else begin
        downstream_in_data[(l-CH)*W +: W] = data;
        downstream_in_valid[l-CH]         = valid;
    end
endtask

// valid as the testbench drives it on lane l
function automatic logic lane_valid(int l);
    if (l < CH) begin
        return upstream_in_valid[l];
    end
    return downstream_in_valid[l-CH];
endfunction

task automatic set_out_ready(int l, logic rdy);
    if (l < CH) begin
        downstream_out_ready[l] = rdy;
    end else begin
        upstream_out_ready[l-CH] = rdy;
    end
endtask

task automatic set_all_ready(logic rdy);
    for (int l = 0; l < LANES; l++) begin
        set_out_ready(l, rdy);
    end
endtask

task automatic idle_all();
    for (int l = 0; l < LANES; l++) begin
        drive_word(l, '0, 1'b0);
    end
endtask

function automatic logic queues_empty();
    for (int l = 0; l < LANES; l++) begin
        if (ref_data[l].size() != 0) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

task automatic wait_drain(int limit);
    int waited;
    waited = 0;
    while (!queues_empty() && waited < limit) begin
        next_cycle();
        waited++;
    end
    check_true(queues_empty(), "words still in flight after the drain limit");
endtask

task automatic check_idle_state();
    check_value("out_valid after reset", 0, 32'(all_out_valid));
    check_value("in_ready after reset", (1 << LANES) - 1, 32'(all_in_ready));
    check_value("upstream_has_message_flying after reset", 0,
        32'(upstream_has_message_flying));
    check_value("upstream_has_odd_clusters after reset", 0, 32'(upstream_has_odd_clusters));
endtask

task automatic test_single_latency();
    int seen_before [LANES];
    test_name = "test_single_latency";
    set_all_ready(1'b1);
    for (int l = 0; l < LANES; l++) begin
        seen_before[l] = out_seen[l];
    end
    check_exact = 1'b1;
    for (int l = 0; l < LANES; l++) begin
        drive_word(l, link_pkg::word_t'($urandom), 1'b1);
    end
    next_cycle();
    idle_all();
    wait_drain(DRAIN_LIMIT);
    check_exact = 1'b0;
    for (int l = 0; l < LANES; l++) begin
        check_value($sformatf("lane %0d words delivered", l), 1, out_seen[l] - seen_before[l]);
    end
endtask

task automatic test_burst_order(int len);
    int seen_before [LANES];
    test_name = "test_burst_order";
    set_all_ready(1'b1);
    for (int l = 0; l < LANES; l++) begin
        seen_before[l] = out_seen[l];
    end
    for (int seq = 0; seq < len; seq++) begin
        for (int l = 0; l < LANES; l++) begin
            drive_word(l, tag_word(l, seq), 1'b1);
        end
        next_cycle();
    end
    idle_all();
    wait_drain(DRAIN_LIMIT);
    for (int l = 0; l < LANES; l++) begin
        check_value($sformatf("lane %0d words delivered", l), len, out_seen[l] - seen_before[l]);
    end
endtask

task automatic test_backpressure(int stall);
    int accepted;
    int seq;
    int seen_before;
    test_name   = "test_backpressure";
    accepted    = 0;
    seq         = 0;
    seen_before = out_seen[stall];
    for (int l = 0; l < LANES; l++) begin
        set_out_ready(l, l != stall);
    end
    // other lanes keep streaming while the stalled lane fills
    while (all_in_ready[stall] && accepted <= link_pkg::FIFO_DEPTH) begin
        for (int l = 0; l < LANES; l++) begin
            drive_word(l, tag_word(l, seq), 1'b1);
        end
        next_cycle();
        accepted++;
        seq++;
    end
    check_value("words accepted before in_ready dropped", link_pkg::FIFO_DEPTH, accepted);
    drive_word(stall, '0, 1'b0);
    repeat (8) begin
        for (int l = 0; l < LANES; l++) begin
            if (l != stall) begin
                drive_word(l, tag_word(l, seq), 1'b1);
            end
        end
        next_cycle();
        seq++;
        check_true(!all_in_ready[stall], "full lane raised in_ready while stalled");
        check_true(all_out_valid[stall], "stalled lane dropped out_valid");
    end
    idle_all();
    set_all_ready(1'b1);
    wait_drain(DRAIN_LIMIT);
    check_value("words delivered on stalled lane", link_pkg::FIFO_DEPTH,
        out_seen[stall] - seen_before);
endtask

task automatic test_status_delay(int n);
    link_pkg::chan_mask_t fly_hist [$];
    link_pkg::chan_mask_t odd_hist [$];
    test_name = "test_status_delay";
    for (int j = 0; j < n; j++) begin
        if (j >= link_pkg::STATUS_DELAY) begin
            check_value("upstream_has_message_flying",
                32'(fly_hist[j - link_pkg::STATUS_DELAY]), 32'(upstream_has_message_flying));
            check_value("upstream_has_odd_clusters",
                32'(odd_hist[j - link_pkg::STATUS_DELAY]), 32'(upstream_has_odd_clusters));
        end
        downstream_has_message_flying = link_pkg::chan_mask_t'($urandom);
        downstream_has_odd_clusters   = link_pkg::chan_mask_t'($urandom);
        fly_hist.push_back(downstream_has_message_flying);
        odd_hist.push_back(downstream_has_odd_clusters);
        next_cycle();
    end
    downstream_has_message_flying = '0;
    downstream_has_odd_clusters   = '0;
endtask

task automatic test_reset_clears();
    test_name = "test_reset_clears";
    set_all_ready(1'b0);
    downstream_has_message_flying = '1;
    downstream_has_odd_clusters   = '1;
    // fill every lane to the top
    for (int seq = 0; seq < link_pkg::FIFO_DEPTH; seq++) begin
        for (int l = 0; l < LANES; l++) begin
            drive_word(l, tag_word(l, seq), 1'b1);
        end
        next_cycle();
    end
    idle_all();
    check_value("in_ready with every lane full", 0, 32'(all_in_ready));
    reset = 1'b1;
    repeat (4) next_cycle();
    reset                         = 1'b0;
    downstream_has_message_flying = '0;
    downstream_has_odd_clusters   = '0;
    set_all_ready(1'b1);
    check_idle_state();
    // the monitor flags any word that shows up now
    repeat (20) next_cycle();
    check_value("out_valid long after reset", 0, 32'(all_out_valid));
endtask

task automatic test_random_traffic(int n_cycles);
    logic [LANES-1:0] took;
    test_name = "test_random_traffic";
    took      = '0;
    for (int c = 0; c < n_cycles; c++) begin
        for (int l = 0; l < LANES; l++) begin
            // an offered word holds until it is taken
            if (!lane_valid(l) || took[l]) begin
                drive_word(l, link_pkg::word_t'($urandom), ($urandom % 3) != 0);
            end
            set_out_ready(l, ($urandom % 4) != 0);
        end
        for (int l = 0; l < LANES; l++) begin
            took[l] = lane_valid(l) && all_in_ready[l];
        end
        next_cycle();
    end
    idle_all();
    set_all_ready(1'b1);
    wait_drain(DRAIN_LIMIT);
endtask

`endif

// ==== dv/tb_interconnect.sv ====
`timescale 1ns/1ps

module tb_interconnect;

    localparam int W     = link_pkg::WIDTH;
    localparam int CH    = link_pkg::CHANNELS;
    localparam int LANES = 2 * CH;

    // random run is 2000 cycles, the directed tests and drains add a few hundred
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int DRAIN_LIMIT    = 100;
    localparam logic [31:0] SEED  = 32'h18b4_ee74;

    logic                 clk;
    logic                 reset;

    link_pkg::bus_t       upstream_in_data;
    link_pkg::chan_mask_t upstream_in_valid;
    link_pkg::chan_mask_t upstream_in_ready;
    link_pkg::bus_t       downstream_out_data;
    link_pkg::chan_mask_t downstream_out_valid;
    link_pkg::chan_mask_t downstream_out_ready;

    link_pkg::bus_t       downstream_in_data;
    link_pkg::chan_mask_t downstream_in_valid;
    link_pkg::chan_mask_t downstream_in_ready;
    link_pkg::bus_t       upstream_out_data;
    link_pkg::chan_mask_t upstream_out_valid;
    link_pkg::chan_mask_t upstream_out_ready;

    link_pkg::chan_mask_t downstream_has_message_flying;
    link_pkg::chan_mask_t downstream_has_odd_clusters;
    link_pkg::chan_mask_t upstream_has_message_flying;
    link_pkg::chan_mask_t upstream_has_odd_clusters;

    // lane l = direction * CH + channel, direction 0 is upstream to downstream
    logic [LANES-1:0]   all_in_valid;
    logic [LANES-1:0]   all_in_ready;
    logic [LANES*W-1:0] all_in_data;
    logic [LANES-1:0]   all_out_valid;
    logic [LANES-1:0]   all_out_ready;
    logic [LANES*W-1:0] all_out_data;

    assign all_in_valid  = {downstream_in_valid, upstream_in_valid};
    assign all_in_ready  = {downstream_in_ready, upstream_in_ready};
    assign all_in_data   = {downstream_in_data, upstream_in_data};
    assign all_out_valid = {upstream_out_valid, downstream_out_valid};
    assign all_out_ready = {upstream_out_ready, downstream_out_ready};
    assign all_out_data  = {upstream_out_data, downstream_out_data};

    // reference model, accepted words and their acceptance cycle per lane
    link_pkg::word_t ref_data  [LANES][$];
    int              ref_cycle [LANES][$];
    int              out_seen  [LANES];

    int    cycle       = 0;
    int    errors      = 0;
    int    checks      = 0;
    logic  check_exact = 1'b0;
    string test_name   = "reset";

    `include "tb_tasks.svh"

    interconnect_model DUT (
        .clk                           (clk),
        .reset                         (reset),
        .upstream_in_data              (upstream_in_data),
        .upstream_in_valid             (upstream_in_valid),
        .upstream_in_ready             (upstream_in_ready),
        .downstream_out_data           (downstream_out_data),
        .downstream_out_valid          (downstream_out_valid),
        .downstream_out_ready          (downstream_out_ready),
        .downstream_in_data            (downstream_in_data),
        .downstream_in_valid           (downstream_in_valid),
        .downstream_in_ready           (downstream_in_ready),
        .upstream_out_data             (upstream_out_data),
        .upstream_out_valid            (upstream_out_valid),
        .upstream_out_ready            (upstream_out_ready),
        .downstream_has_message_flying (downstream_has_message_flying),
        .downstream_has_odd_clusters   (downstream_has_odd_clusters),
        .upstream_has_message_flying   (upstream_has_message_flying),
        .upstream_has_odd_clusters     (upstream_has_odd_clusters)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // monitor samples mid-cycle, the transfer happens at the next rising edge
    always @(negedge clk) begin
        link_pkg::word_t exp_word;
        int              sent_at;
        if (reset) begin
            for (int l = 0; l < LANES; l++) begin
                ref_data[l].delete();
                ref_cycle[l].delete();
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (all_in_valid[l] && all_in_ready[l]) begin
                    ref_data[l].push_back(all_in_data[l*W +: W]);
                    ref_cycle[l].push_back(cycle);
                end
                if (all_out_valid[l] && all_out_ready[l]) begin
                    out_seen[l]++;
                    check_true(ref_data[l].size() != 0,
                        $sformatf("lane %0d delivered a word that was never sent", l));
                    if (ref_data[l].size() != 0) begin
                        exp_word = ref_data[l].pop_front();
                        sent_at  = ref_cycle[l].pop_front();
                        check_value($sformatf("lane %0d data", l), 32'(exp_word),
                            32'(all_out_data[l*W +: W]));
                        check_true(cycle - sent_at >= link_pkg::LATENCY,
                            $sformatf("lane %0d released a word after only %0d cycles",
                                l, cycle - sent_at));
                        if (check_exact) begin
                            check_value($sformatf("lane %0d latency", l),
                                link_pkg::LATENCY, cycle - sent_at);
                        end
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset                         = 1'b1;
        upstream_in_data              = '0;
        upstream_in_valid             = '0;
        downstream_out_ready          = '0;
        downstream_in_data            = '0;
        downstream_in_valid           = '0;
        upstream_out_ready            = '0;
        downstream_has_message_flying = '0;
        downstream_has_odd_clusters   = '0;
        for (int l = 0; l < LANES; l++) begin
            out_seen[l] = 0;
        end

        repeat (8) next_cycle();
        reset = 1'b0;
        check_idle_state();

        test_single_latency();
        test_burst_order(12);
        test_backpressure(2);
        test_backpressure(CH + 1);
        test_status_delay(64);
        test_reset_clears();
        test_random_traffic(2000);
        repeat (4) next_cycle();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== design/interconnect_model.sv ====
`timescale 1ns/1ps

module interconnect_model (
    input  logic                 clk,
    input  logic                 reset,

    // upstream to downstream
    input  link_pkg::bus_t       upstream_in_data,
    input  link_pkg::chan_mask_t upstream_in_valid,
    output link_pkg::chan_mask_t upstream_in_ready,
    output link_pkg::bus_t       downstream_out_data,
    output link_pkg::chan_mask_t downstream_out_valid,
    input  link_pkg::chan_mask_t downstream_out_ready,

    // downstream to upstream
    input  link_pkg::bus_t       downstream_in_data,
    input  link_pkg::chan_mask_t downstream_in_valid,
    output link_pkg::chan_mask_t downstream_in_ready,
    output link_pkg::bus_t       upstream_out_data,
    output link_pkg::chan_mask_t upstream_out_valid,
    input  link_pkg::chan_mask_t upstream_out_ready,

    // status flags, downstream side reports to upstream side
    input  link_pkg::chan_mask_t downstream_has_message_flying,
    input  link_pkg::chan_mask_t downstream_has_odd_clusters,
    output link_pkg::chan_mask_t upstream_has_message_flying,
    output link_pkg::chan_mask_t upstream_has_odd_clusters
);

    localparam int W = link_pkg::WIDTH;

    link_pkg::stamp_t     now_count;
    link_pkg::chan_mask_t flying_pipe [link_pkg::STATUS_DELAY];
    link_pkg::chan_mask_t odd_pipe    [link_pkg::STATUS_DELAY];

    // free-running cycle count, shared by every lane
    always_ff @(posedge clk) begin
        if (reset) begin
            now_count <= '0;
        end else begin
            now_count <= now_count + link_pkg::stamp_t'(1);
        end
    end

    for (genvar i = 0; i < link_pkg::CHANNELS; i++) begin : g_chan

        // upstream side writes, downstream side reads
        delay_lane u_lane_down (
            .clk       (clk),
            .reset     (reset),
            .now       (now_count),
            .in_data   (upstream_in_data[i*W +: W]),
            .in_valid  (upstream_in_valid[i]),
            .in_ready  (upstream_in_ready[i]),
            .out_data  (downstream_out_data[i*W +: W]),
            .out_valid (downstream_out_valid[i]),
            .out_ready (downstream_out_ready[i])
        );

        // downstream side writes, upstream side reads
        delay_lane u_lane_up (
            .clk       (clk),
            .reset     (reset),
            .now       (now_count),
            .in_data   (downstream_in_data[i*W +: W]),
            .in_valid  (downstream_in_valid[i]),
            .in_ready  (downstream_in_ready[i]),
            .out_data  (upstream_out_data[i*W +: W]),
            .out_valid (upstream_out_valid[i]),
            .out_ready (upstream_out_ready[i])
        );

    end

    // status shift chain, stage 0 samples the downstream inputs
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < link_pkg::STATUS_DELAY; s++) begin
                flying_pipe[s] <= '0;
                odd_pipe[s]    <= '0;
            end
        end else begin
            flying_pipe[0] <= downstream_has_message_flying;
            odd_pipe[0]    <= downstream_has_odd_clusters;
            for (int s = 1; s < link_pkg::STATUS_DELAY; s++) begin
                flying_pipe[s] <= flying_pipe[s-1];
                odd_pipe[s]    <= odd_pipe[s-1];
            end
        end
    end

    // last stage drives the upstream side
    assign upstream_has_message_flying = flying_pipe[link_pkg::STATUS_DELAY-1];
    assign upstream_has_odd_clusters   = odd_pipe[link_pkg::STATUS_DELAY-1];

endmodule

// ==== design/delay_lane.sv ====
`timescale 1ns/1ps

module delay_lane (
    input  logic             clk,
    input  logic             reset,
    input  link_pkg::stamp_t now,
    input  link_pkg::word_t  in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output link_pkg::word_t  out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int ENTRY_W = link_pkg::WIDTH + link_pkg::STAMP_WIDTH;

    logic [ENTRY_W-1:0] entry_in;
    logic [ENTRY_W-1:0] entry_head;
    link_pkg::stamp_t   release_stamp;
    link_pkg::stamp_t   head_stamp;
    logic               fifo_full;
    logic               fifo_empty;
    logic               wr_en;
    logic               rd_en;
    logic               head_due;

    // word accepted at cycle c leaves no earlier than c + LATENCY
    assign release_stamp = now + link_pkg::stamp_t'(link_pkg::LATENCY);
    assign entry_in      = {in_data, release_stamp};

    assign in_ready = !fifo_full;
    assign wr_en    = in_valid && in_ready;

    // word and stamp travel together through the buffer
    assign {out_data, head_stamp} = entry_head;

    // head is due once its release cycle has come
    assign head_due  = !fifo_empty && (head_stamp <= now);
    assign out_valid = head_due;
    assign rd_en     = head_due && out_ready;

    fifo_fwft #(
        .DEPTH (link_pkg::FIFO_DEPTH),
        .WIDTH (ENTRY_W)
    ) u_fifo (
        .clk   (clk),
        .reset (reset),
        .wr_en (wr_en),
        .din   (entry_in),
        .rd_en (rd_en),
        .dout  (entry_head),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

    // stalled output must hold its word until taken
    a_hold_when_stalled : assert property (
        @(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("delay_lane: output changed while stalled");

endmodule

// ==== design/fifo_fwft.sv ====
`timescale 1ns/1ps

module fifo_fwft #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    // flags come straight from the occupancy count
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // a write into a full buffer or a read from an empty one is dropped
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    // head entry is always presented
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_ok) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy, unchanged when a read and a write meet
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the user must honour the flags
    a_no_write_when_full : assert property (
        @(posedge clk) disable iff (reset)
        !(wr_en && full)
    ) else $error("fifo_fwft: write while full");

    a_no_read_when_empty : assert property (
        @(posedge clk) disable iff (reset)
        !(rd_en && empty)
    ) else $error("fifo_fwft: read while empty");

endmodule

// ==== design/link_pkg.sv ====
package link_pkg;

    // payload width of one channel word
    localparam int WIDTH = 16;

    // parallel lanes per direction
    localparam int CHANNELS = 4;

    // cycles from acceptance to release on the far side
    localparam int LATENCY = 3;

    // buffer entries per lane
    localparam int FIFO_DEPTH = 16;

    // cycle counter and release stamp width
    localparam int STAMP_WIDTH = 32;

    // register stages on the downstream-to-upstream status flags
    localparam int STATUS_DELAY = 2;

    typedef logic [WIDTH-1:0] word_t;

    // channel i sits in bits [i*WIDTH +: WIDTH]
    typedef logic [WIDTH*CHANNELS-1:0] bus_t;

    typedef logic [STAMP_WIDTH-1:0] stamp_t;

    typedef logic [CHANNELS-1:0] chan_mask_t;

endpackage
